// ==== Bender.yml ====
package:
  name: rsc_dec_input

sources:
  - files:
      - source/rsc_dec_pkg.sv
      - source/rsc_dec_source.sv
      - source/rsc_dec_page_ctrl.sv
      - source/rsc_dec_depunct_buf.sv
      - source/rsc_dec_sym_reader.sv
      - source/rsc_dec_input.sv
  - target: simulation
    files:
      - sim/tb_rsc_dec_input.sv

// ==== build.f ====
source/rsc_dec_pkg.sv
source/rsc_dec_source.sv
source/rsc_dec_page_ctrl.sv
source/rsc_dec_depunct_buf.sv
source/rsc_dec_sym_reader.sv
source/rsc_dec_input.sv
sim/tb_rsc_dec_input.sv

// ==== sim/tb_rsc_dec_input.sv ====
/*
  testbench of the decoder input stage, sends a table of framed LLR streams,
  rebuilds the depunctured symbols and checks them under credit back-pressure
*/
`timescale 1ns/100ps

module tb_rsc_dec_input;

  localparam int ADDR_W  = 6;
  localparam int DTAG_W  = 8;
  localparam int CREDITS = 4;
  localparam int NF      = 9;          // frames in the table
  localparam int MAXN    = 2**ADDR_W;  // symbols per page

  logic               iclk = 1'b0;
  logic               ireset;
  logic               isop, ieop, ival;
  logic [4:0]         illr0, illr1;
  logic [DTAG_W-1:0]  itag;
  logic [3:0]         icode;
  logic [7:0]         in;
  logic               icredit;
  logic               ordy, busy, ovalid, osop, oeop;
  logic [4:0]         os0, os1, oy0, oy1, ow0, ow1;
  logic [DTAG_W-1:0]  otag;

  integer          seed = 32'hc39e_7782;
  logic [5:0][4:0] exp_sym [NF*MAXN];  // lanes s0 s1 y0 y1 w0 w1, low lane first
  logic [9:0]      wq [$];             // words of the frame being sent, {llr1, llr0}
  int              sent_cnt = 0;       // frames fully sent
  int              done_cnt = 0;       // frames fully received
  int              sym_cnt = 0;        // symbol index inside the frame on the output
  int              ovalid_cnt = 0;
  int              ret_seen = 0;       // credit pulses already seen by the DUT
  int              ret_issued = 0;
  int              stalls = 0;         // back-pressure waits with ordy still low
  int              errors = 0;
  int              cycles = 0;
  int              limit;
  bit              hold = 1'b0;        // credits withheld

  always #50 iclk = ~iclk;

  rsc_dec_input #(
    .pLLR_W(5), .pADDR_W(ADDR_W), .pDTAG_W(DTAG_W), .pCREDITS(CREDITS)
  ) uut (
    .iclk(iclk), .ireset(ireset), .isop(isop), .ieop(ieop), .ival(ival),
    .illr0(illr0), .illr1(illr1), .itag(itag), .icode(icode), .in(in),
    .ordy(ordy), .busy(busy), .icredit(icredit), .ovalid(ovalid), .osop(osop),
    .oeop(oeop), .os0(os0), .os1(os1), .oy0(oy0), .oy1(oy1), .ow0(ow0),
    .ow1(ow1), .otag(otag)
  );

  //------------------------------------------------------------
  // frame table and reference rules
  //------------------------------------------------------------
  // {mode, code, N, tag}, mode 1 withholds credits until both pages fill
  function automatic logic [20:0] frame_row(int i);
    logic [20:0] r;
    case (i)
      0       : r = {1'b0, 4'd0,  8'd16, 8'h11};  // 1/3
      1       : r = {1'b0, 4'd1,  8'd13, 8'h22};  // 1/2
      2       : r = {1'b0, 4'd2,  8'd20, 8'h33};  // 2/3
      3       : r = {1'b0, 4'd11, 8'd17, 8'h44};  // 3/5
      4       : r = {1'b0, 4'd12, 8'd19, 8'h55};  // 3/7
      5       : r = {1'b1, 4'd10, 8'd24, 8'h66};  // 2/5
      6       : r = {1'b1, 4'd8,  8'd33, 8'h77};  // 8/9
      7       : r = {1'b1, 4'd9,  8'd64, 8'h88};  // 9/10, full page
      8       : r = {1'b0, 4'd7,  8'd1,  8'h99};  // 7/8 as 8/9, single symbol
      default : r = '0;
    endcase
    return r;
  endfunction

  // rate k/(k+1) keeps one Y pair in k symbols, 3/5 and 3/7 keep two in three
  function automatic int y_inc(int code, bit sel);
    int s;
    case (code)
      0, 1, 10 : s = 1;
      2, 3, 4, 5, 6 : s = code;
      7, 8     : s = 8;
      9        : s = 9;
      default  : s = sel ? 1 : 2;
    endcase
    return s;
  endfunction

  // W survives only at 1/3 (all), 2/5 (every other) and 3/7 (two in three)
  function automatic int w_inc(int code, bit sel);
    int s;
    case (code)
      0       : s = 1;
      10      : s = 2;
      12      : s = sel ? 1 : 2;
      default : s = 0;
    endcase
    return s;
  endfunction

  function automatic logic [4:0] clip_llr(logic [4:0] v);
    return (v == 5'h10) ? 5'h11 : v;  // -16 comes back as -15
  endfunction

  function automatic logic [4:0] rand_llr();
    integer r;
    r = $random(seed);
    return (r[2:0] == 3'd0) ? 5'h10 : r[12:8];  // extra share of -16
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] act,
                           input logic [31:0] exp);
    if (act !== exp) begin
      errors = errors + 1;
      $display("error %s: got %h, expected %h", name, act, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  //------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------
  // surviving parity pairs of one bank, expected lanes filled as they go
  task automatic add_parity(int f, int n, int code, bit is_w);
    int         a;
    int         lane;
    bit         sel;
    logic [4:0] l0;
    logic [4:0] l1;
    a    = 0;
    sel  = 1'b0;
    lane = is_w ? 4 : 2;
    while (a < n) begin
      l0 = rand_llr();
      l1 = rand_llr();
      wq.push_back({l1, l0});
      exp_sym[f*MAXN+a][lane]   = clip_llr(l0);
      exp_sym[f*MAXN+a][lane+1] = clip_llr(l1);
      a   = a + (is_w ? w_inc(code, sel) : y_inc(code, sel));
      sel = ~sel;
    end
  endtask

  task automatic send_frame(int f);
    logic [20:0] row;
    int          n;
    logic [4:0]  l0;
    logic [4:0]  l1;
    row = frame_row(f);
    n   = row[15:8];
    wq.delete();
    for (int k = 0; k < MAXN; k++) begin
      exp_sym[f*MAXN+k] = '0;  // punctured until a pair lands
    end
    for (int k = 0; k < n; k++) begin
      l0 = (k == 0) ? 5'h10 : rand_llr();  // every frame opens with -16
      l1 = rand_llr();
      wq.push_back({l1, l0});
      exp_sym[f*MAXN+k][0] = clip_llr(l0);
      exp_sym[f*MAXN+k][1] = clip_llr(l1);
    end
    add_parity(f, n, row[19:16], 1'b0);
    if (w_inc(row[19:16], 1'b0) != 0) begin
      add_parity(f, n, row[19:16], 1'b1);
    end
    for (int j = 0; j < wq.size(); j++) begin
      @(posedge iclk);
      isop  <= (j == 0);
      ieop  <= (j == wq.size() - 1);
      ival  <= 1'b1;
      illr0 <= wq[j][4:0];
      illr1 <= wq[j][9:5];
      icode <= row[19:16];
      in    <= row[15:8];
      itag  <= row[7:0];
    end
    repeat (2) begin  // frame_done settles into ordy
      @(posedge iclk);
      isop <= 1'b0;
      ieop <= 1'b0;
      ival <= 1'b0;
    end
    sent_cnt = sent_cnt + 1;
  endtask

  // ordy is judged at sop, a stall with credits held is checked then released
  task automatic wait_ready();
    @(negedge iclk);
    while (!ordy) begin
      if (hold) begin
        repeat (20) @(negedge iclk);
        expect_eq("ordy", ordy, (sent_cnt - done_cnt) < 2);
        expect_eq("busy", busy, (sent_cnt - done_cnt) > 0);
        if (!ordy) begin
          stalls = stalls + 1;
        end
        hold = 1'b0;
      end else begin
        @(negedge iclk);
      end
    end
  endtask

  //------------------------------------------------------------
  // credit return, one pulse per received symbol unless held
  //------------------------------------------------------------
  always @(posedge iclk) begin
    if (ireset) begin
      icredit <= 1'b0;
    end else if (!hold && ret_issued < ovalid_cnt) begin
      icredit    <= 1'b1;
      ret_issued = ret_issued + 1;
    end else begin
      icredit <= 1'b0;
    end
  end

  // output monitor
  always @(negedge iclk) begin : monitor
    logic [20:0] row;
    int          idx;
    if (!ireset && ovalid) begin
      row        = frame_row(done_cnt);
      idx        = done_cnt * MAXN + sym_cnt;
      ovalid_cnt = ovalid_cnt + 1;
      expect_eq("frame index", done_cnt < NF, 1);
      expect_eq("ovalid within credits", ovalid_cnt <= CREDITS + ret_seen, 1);
      expect_eq("osop", osop, sym_cnt == 0);
      expect_eq("oeop", oeop, sym_cnt == row[15:8] - 1);
      expect_eq("otag", otag, row[7:0]);
      expect_eq("os0", os0, exp_sym[idx][0]);
      expect_eq("os1", os1, exp_sym[idx][1]);
      expect_eq("oy0", oy0, exp_sym[idx][2]);
      expect_eq("oy1", oy1, exp_sym[idx][3]);
      expect_eq("ow0", ow0, exp_sym[idx][4]);
      expect_eq("ow1", ow1, exp_sym[idx][5]);
      if (oeop) begin
        done_cnt = done_cnt + 1;
        sym_cnt  = 0;
      end else begin
        sym_cnt = sym_cnt + 1;
      end
    end
    if (!ireset && icredit) begin
      ret_seen = ret_seen + 1;
    end
  end

  always @(posedge iclk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, only %0d of %0d frames came out",
               cycles, done_cnt, NF);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  //------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------
  initial begin : main
    logic [20:0] row;
    ireset  = 1'b1;
    isop    = 1'b0;
    ieop    = 1'b0;
    ival    = 1'b0;
    illr0   = '0;
    illr1   = '0;
    itag    = '0;
    icode   = '0;
    in      = '0;
    icredit = 1'b0;
    limit   = 200;
    for (int f = 0; f < NF; f++) begin
      row   = frame_row(f);
      limit = limit + 4 * row[15:8];
    end
    repeat (9) @(posedge iclk);
    @(negedge iclk);
    expect_eq("ovalid", ovalid, 0);
    expect_eq("busy", busy, 0);
    expect_eq("ordy", ordy, 1);
    @(posedge iclk);
    ireset <= 1'b0;  // tenth reset cycle ends here
    for (int f = 0; f < NF; f++) begin
      row = frame_row(f);
      if (row[20]) begin
        hold = 1'b1;
      end
      wait_ready();
      send_frame(f);
    end
    hold = 1'b0;
    while (done_cnt < NF) begin
      @(negedge iclk);
    end
    repeat (3) @(negedge iclk);
    expect_eq("busy", busy, 0);
    expect_eq("ordy", ordy, 1);
    expect_eq("ordy low with both pages held", stalls != 0, 1);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/rsc_dec_depunct_buf.sv ====
/*
  two-page S/Y/W pair memory of the input stage, a per-entry written flag
  turns punctured positions into zero LLRs on read
*/
`timescale 1ns/100ps

module rsc_dec_depunct_buf #(
  parameter int pADDR_W = 6
) (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                wr,
  input  logic                wpage,
  input  rsc_dec_pkg::bank_t  wbank,
  input  logic [pADDR_W-1:0]  waddr,
  input  rsc_dec_pkg::llr_t   wllr0,
  input  rsc_dec_pkg::llr_t   wllr1,
  input  logic                rd,
  input  logic                rpage,
  input  logic [pADDR_W-1:0]  raddr,
  input  logic                page_free,
  output rsc_dec_pkg::llr_t   rs0,
  output rsc_dec_pkg::llr_t   rs1,
  output rsc_dec_pkg::llr_t   ry0,
  output rsc_dec_pkg::llr_t   ry1,
  output rsc_dec_pkg::llr_t   rw0,
  output rsc_dec_pkg::llr_t   rw1
);

  localparam int cW     = rsc_dec_pkg::cLLR_W;
  localparam int cHALF  = 2**pADDR_W;  // entries per page
  localparam int cDEPTH = 2*cHALF;

  typedef logic [2*cW-1:0] pair_t;  // {llr1, llr0}

  pair_t              mem  [3][cDEPTH];  // 0 S, 1 Y, 2 W
  logic [cDEPTH-1:0]  flag [3];          // entry written in this frame
  logic [2:0]         wsel;
  logic [pADDR_W:0]   widx;
  logic [pADDR_W:0]   ridx;
  logic [cDEPTH-1:0]  clr_mask;          // all entries of the freed page
  pair_t              pair_q [3];
  logic [2:0]         flag_q;
  pair_t              pair_o [3];

  assign wsel     = {3{wr}} & {wbank == rsc_dec_pkg::BANK_W,
                               wbank == rsc_dec_pkg::BANK_Y,
                               wbank == rsc_dec_pkg::BANK_S};
  assign widx     = {wpage, waddr};
  assign ridx     = {rpage, raddr};
  assign clr_mask = rpage ? {{cHALF{1'b1}}, {cHALF{1'b0}}}
                          : {{cHALF{1'b0}}, {cHALF{1'b1}}};

  //------------------------------------------------------------
  // pair storage and registered read
  //------------------------------------------------------------
  always_ff @(posedge iclk) begin
    for (int b = 0; b < 3; b++) begin
      if (wsel[b]) begin
        mem[b][widx] <= {wllr1, wllr0};
      end
      if (rd) begin
        pair_q[b] <= mem[b][ridx];
        flag_q[b] <= flag[b][ridx];
      end
    end
  end

  // written flags, whole page cleared when the reader lets it go
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      for (int b = 0; b < 3; b++) begin
        flag[b] <= '0;
      end
    end else begin
      for (int b = 0; b < 3; b++) begin
        if (page_free) begin
          flag[b] <= flag[b] & ~clr_mask;
        end
        if (wsel[b]) begin
          flag[b][widx] <= 1'b1;
        end
      end
    end
  end

  //------------------------------------------------------------
  // punctured entries read as zero
  always_comb begin
    for (int b = 0; b < 3; b++) begin
      pair_o[b] = flag_q[b] ? pair_q[b] : '0;
    end
  end

  assign rs0 = pair_o[0][cW-1:0];
  assign rs1 = pair_o[0][2*cW-1:cW];
  assign ry0 = pair_o[1][cW-1:0];
  assign ry1 = pair_o[1][2*cW-1:cW];
  assign rw0 = pair_o[2][cW-1:0];
  assign rw1 = pair_o[2][2*cW-1:cW];

endmodule

// ==== source/rsc_dec_input.sv ====
/*
  input stage of the duobinary RSC decoder, framed LLR pairs in,
  depunctured S/Y/W symbols out under credit flow control
*/
`timescale 1ns/100ps

module rsc_dec_input #(
  parameter int pLLR_W   = rsc_dec_pkg::cLLR_W,  // must equal the package width
  parameter int pADDR_W  = 6,
  parameter int pDTAG_W  = 8,
  parameter int pCREDITS = 4   // downstream buffer depth
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     isop,
  input  logic                     ieop,
  input  logic                     ival,
  input  logic [pLLR_W-1:0]        illr0,
  input  logic [pLLR_W-1:0]        illr1,
  input  logic [pDTAG_W-1:0]       itag,
  input  rsc_dec_pkg::code_t       icode,
  input  rsc_dec_pkg::dbits_num_t  in,
  output logic                     ordy,
  output logic                     busy,
  input  logic                     icredit,
  output logic                     ovalid,
  output logic                     osop,
  output logic                     oeop,
  output logic [pLLR_W-1:0]        os0,
  output logic [pLLR_W-1:0]        os1,
  output logic [pLLR_W-1:0]        oy0,
  output logic [pLLR_W-1:0]        oy1,
  output logic [pLLR_W-1:0]        ow0,
  output logic [pLLR_W-1:0]        ow1,
  output logic [pDTAG_W-1:0]       otag
);

  logic                     wr;
  rsc_dec_pkg::bank_t       wbank;
  logic [pADDR_W-1:0]       waddr;
  rsc_dec_pkg::llr_t        wllr0, wllr1;
  logic                     frame_done;
  rsc_dec_pkg::dbits_num_t  frame_n;
  logic [pDTAG_W-1:0]       frame_tag;
  logic                     wpage, rpage, rvalid_page, full, page_free;
  rsc_dec_pkg::dbits_num_t  rn;
  logic [pDTAG_W-1:0]       rtag;
  logic                     rd;
  logic [pADDR_W-1:0]       raddr;
  rsc_dec_pkg::llr_t        rs0, rs1, ry0, ry1, rw0, rw1;

  assign ordy = ~full;  // sender checks it at sop only

  //------------------------------------------------------------
  rsc_dec_source #(.pADDR_W(pADDR_W), .pDTAG_W(pDTAG_W)) u_source (
    .iclk(iclk), .ireset(ireset), .isop(isop), .ieop(ieop), .ival(ival),
    .illr0(illr0), .illr1(illr1), .itag(itag), .icode(icode), .in(in),
    .wr(wr), .wbank(wbank), .waddr(waddr), .wllr0(wllr0), .wllr1(wllr1),
    .frame_done(frame_done), .frame_code(), .frame_n(frame_n), .frame_tag(frame_tag)
  );  // rate stays inside the source, buffer holds the depunctured result

  rsc_dec_page_ctrl #(.pADDR_W(pADDR_W), .pDTAG_W(pDTAG_W)) u_page_ctrl (
    .iclk(iclk), .ireset(ireset), .frame_done(frame_done), .frame_n(frame_n),
    .frame_tag(frame_tag), .page_free(page_free), .wpage(wpage), .rpage(rpage),
    .rvalid_page(rvalid_page), .rn(rn), .rtag(rtag), .full(full), .busy(busy)
  );

  rsc_dec_depunct_buf #(.pADDR_W(pADDR_W)) u_buf (
    .iclk(iclk), .ireset(ireset), .wr(wr), .wpage(wpage), .wbank(wbank),
    .waddr(waddr), .wllr0(wllr0), .wllr1(wllr1), .rd(rd), .rpage(rpage),
    .raddr(raddr), .page_free(page_free), .rs0(rs0), .rs1(rs1), .ry0(ry0),
    .ry1(ry1), .rw0(rw0), .rw1(rw1)
  );

  rsc_dec_sym_reader #(.pADDR_W(pADDR_W), .pDTAG_W(pDTAG_W), .pCREDITS(pCREDITS)) u_reader (
    .iclk(iclk), .ireset(ireset), .rvalid_page(rvalid_page), .rn(rn), .rtag(rtag),
    .rs0(rs0), .rs1(rs1), .ry0(ry0), .ry1(ry1), .rw0(rw0), .rw1(rw1),
    .icredit(icredit), .rd(rd), .raddr(raddr), .page_free(page_free),
    .ovalid(ovalid), .osop(osop), .oeop(oeop), .os0(os0), .os1(os1),
    .oy0(oy0), .oy1(oy1), .ow0(ow0), .ow1(ow1), .otag(otag)
  );

endmodule

// ==== source/rsc_dec_page_ctrl.sv ====
/*
  page ownership of the two-page depuncture buffer, holds N and tag
  of each stored frame and hands full pages to the symbol reader
*/
`timescale 1ns/100ps

module rsc_dec_page_ctrl #(
  parameter int pADDR_W = 6,
  parameter int pDTAG_W = 8
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     frame_done,
  input  rsc_dec_pkg::dbits_num_t  frame_n,
  input  logic [pDTAG_W-1:0]       frame_tag,
  input  logic                     page_free,
  output logic                     wpage,
  output logic                     rpage,
  output logic                     rvalid_page,
  output rsc_dec_pkg::dbits_num_t  rn,
  output logic [pDTAG_W-1:0]       rtag,
  output logic                     full,
  output logic                     busy
);

  logic [1:0]               occ;      // page holds a complete frame
  rsc_dec_pkg::dbits_num_t  n_r   [2];
  logic [pDTAG_W-1:0]       tag_r [2];

  //------------------------------------------------------------
  // write and read pointers, occupied flags
  //------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      occ   <= 2'b00;
      wpage <= 1'b0;
      rpage <= 1'b0;
    end else begin
      if (frame_done) begin
        occ[wpage] <= 1'b1;
        wpage      <= ~wpage;  // next frame goes to the other page
      end
      if (page_free) begin
        occ[rpage] <= 1'b0;    // reader is done, page reusable
        rpage      <= ~rpage;
      end
    end
  end

  // frame parameters per page
  always_ff @(posedge iclk) begin
    if (frame_done) begin
      n_r[wpage]   <= frame_n;
      tag_r[wpage] <= frame_tag;
    end
  end

  assign rvalid_page = occ[rpage];  // page at the read pointer holds a frame
  assign rn          = n_r[rpage];
  assign rtag        = tag_r[rpage];
  assign full        = &occ;  // both pages wait for the reader
  assign busy        = |occ;

endmodule

// ==== source/rsc_dec_pkg.sv ====
/*
  shared widths, types and puncture step tables of the decoder input stage
  referenced by scoped names from the RTL and the testbench model
*/
package rsc_dec_pkg;

  localparam int cLLR_W   = 5;  // soft value width
  localparam int cCODE_W  = 4;  // code rate index width
  localparam int cDBITS_W = 8;  // symbol count width

  typedef logic [cLLR_W-1:0]   llr_t;
  typedef logic [cCODE_W-1:0]  code_t;       // 0..12
  typedef logic [cDBITS_W-1:0] dbits_num_t;  // duobit symbols per frame

  // bank of a buffer word, also the source FSM state
  typedef enum logic [1:0] {
    BANK_NONE = 2'b00,
    BANK_Y    = 2'b01,
    BANK_W    = 2'b10,
    BANK_S    = 2'b11
  } bank_t;

  //------------------------------------------------------------
  // address increment between surviving Y pairs
  function automatic logic [3:0] y_step(code_t code, logic sel);
    logic [3:0] step;
    case (code)
      4'd0, 4'd1, 4'd10 : step = 4'd1;  // 1/3, 1/2, 2/5
      4'd2              : step = 4'd2;  // 2/3
      4'd3              : step = 4'd3;  // 3/4
      4'd4              : step = 4'd4;  // 4/5
      4'd5              : step = 4'd5;  // 5/6
      4'd6              : step = 4'd6;  // 6/7
      4'd7, 4'd8        : step = 4'd8;  // 7/8 runs as 8/9
      4'd9              : step = 4'd9;  // 9/10
      4'd11, 4'd12      : step = sel ? 4'd1 : 4'd2;  // 3/5, 3/7 uneven
      default           : step = 4'd1;
    endcase
    return step;
  endfunction

  // address increment between surviving W pairs, 0 when no W bank
  function automatic logic [3:0] w_step(code_t code, logic sel);
    logic [3:0] step;
    case (code)
      4'd0    : step = 4'd1;                  // 1/3
      4'd10   : step = 4'd2;                  // 2/5
      4'd12   : step = sel ? 4'd1 : 4'd2;     // 3/7
      default : step = 4'd0;
    endcase
    return step;
  endfunction

endpackage

// ==== source/rsc_dec_source.sv ====
/*
  frame parser of the input stage, saturates LLR pairs and maps each word
  to a bank and address of the depuncture buffer by the puncture pattern
*/
`timescale 1ns/100ps

module rsc_dec_source #(
  parameter int pADDR_W = 6,
  parameter int pDTAG_W = 8
) (
  input  logic                       iclk,
  input  logic                       ireset,
  input  logic                       isop,
  input  logic                       ieop,
  input  logic                       ival,
  input  rsc_dec_pkg::llr_t          illr0,
  input  rsc_dec_pkg::llr_t          illr1,
  input  logic [pDTAG_W-1:0]         itag,
  input  rsc_dec_pkg::code_t         icode,
  input  rsc_dec_pkg::dbits_num_t    in,
  output logic                       wr,
  output rsc_dec_pkg::bank_t         wbank,
  output logic [pADDR_W-1:0]         waddr,
  output rsc_dec_pkg::llr_t          wllr0,
  output rsc_dec_pkg::llr_t          wllr1,
  output logic                       frame_done,
  output rsc_dec_pkg::code_t         frame_code,
  output rsc_dec_pkg::dbits_num_t    frame_n,
  output logic [pDTAG_W-1:0]         frame_tag
);

  localparam int cW = rsc_dec_pkg::cLLR_W;

  typedef logic [pADDR_W:0] ext_addr_t;  // spare bit catches overrun past N-1

  rsc_dec_pkg::bank_t   state;      // bank of the next word
  rsc_dec_pkg::bank_t   cur_bank;
  rsc_dec_pkg::bank_t   nxt_state;
  rsc_dec_pkg::code_t   cur_code;
  logic [pADDR_W-1:0]   addr;       // address of the next word
  logic [pADDR_W-1:0]   cur_addr;
  logic [pADDR_W-1:0]   nxt_addr;
  logic [pADDR_W-1:0]   last;       // N-1 of the frame in progress
  logic [pADDR_W-1:0]   in_last;
  logic [pADDR_W-1:0]   cur_last;
  logic                 sel;        // alternates the uneven step halves
  logic                 nxt_sel;
  logic [3:0]           step;
  ext_addr_t            step_addr;

  // most negative code maps to its negation plus one, rest pass
  function automatic rsc_dec_pkg::llr_t sat(rsc_dec_pkg::llr_t v);
    rsc_dec_pkg::llr_t r;
    if (v == {1'b1, {(cW-1){1'b0}}}) begin
      r = {1'b1, {(cW-2){1'b0}}, 1'b1};  // -2^(W-1) -> -(2^(W-1)-1)
    end else begin
      r = v;
    end
    return r;
  endfunction

  //------------------------------------------------------------
  // bank and address of the current word, next position
  //------------------------------------------------------------
  assign in_last = pADDR_W'(in - 1'b1);

  always_comb begin
    cur_bank  = isop ? rsc_dec_pkg::BANK_S : state;  // sop restarts the frame
    cur_addr  = isop ? '0 : addr;
    cur_code  = isop ? icode : frame_code;
    cur_last  = isop ? in_last : last;
    step      = (cur_bank == rsc_dec_pkg::BANK_W) ? rsc_dec_pkg::w_step(cur_code, sel)
                                                  : rsc_dec_pkg::y_step(cur_code, sel);
    step_addr = {1'b0, cur_addr} + ext_addr_t'(step);
    nxt_state = cur_bank;
    nxt_addr  = cur_addr;
    nxt_sel   = sel;
    case (cur_bank)
      rsc_dec_pkg::BANK_S : begin
        if (cur_addr == cur_last) begin  // systematic part done
          nxt_state = rsc_dec_pkg::BANK_Y;
          nxt_addr  = '0;
          nxt_sel   = 1'b0;
        end else begin
          nxt_addr  = cur_addr + 1'b1;
        end
      end
      rsc_dec_pkg::BANK_Y, rsc_dec_pkg::BANK_W : begin
        if (step_addr > {1'b0, cur_last}) begin  // next pair would fall past N-1
          if (cur_bank == rsc_dec_pkg::BANK_Y &&
              rsc_dec_pkg::w_step(cur_code, 1'b0) != 4'd0) begin
            nxt_state = rsc_dec_pkg::BANK_W;
          end else begin
            nxt_state = rsc_dec_pkg::BANK_NONE;  // rest of frame carries nothing
          end
          nxt_addr  = '0;
          nxt_sel   = 1'b0;
        end else begin
          nxt_addr  = step_addr[pADDR_W-1:0];
          nxt_sel   = ~sel;
        end
      end
      default : ;  // idle until the next sop
    endcase
  end

  //------------------------------------------------------------
  // control registers
  //------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state      <= rsc_dec_pkg::BANK_NONE;
      addr       <= '0;
      sel        <= 1'b0;
      wr         <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      wr         <= ival & (cur_bank != rsc_dec_pkg::BANK_NONE);
      frame_done <= ival & ieop;  // registered with the last word
      if (ival) begin
        state <= nxt_state;
        addr  <= nxt_addr;
        sel   <= nxt_sel;
      end
    end
  end

  // write payload and frame parameters
  always_ff @(posedge iclk) begin
    if (ival) begin
      wbank <= cur_bank;
      waddr <= cur_addr;
      wllr0 <= sat(illr0);
      wllr1 <= sat(illr1);
      if (isop) begin
        frame_code <= icode;
        frame_n    <= in;
        frame_tag  <= itag;
        last       <= in_last;
      end
    end
  end

endmodule

// ==== source/rsc_dec_sym_reader.sv ====
/*
  reads a full page symbol by symbol and sends S/Y/W downstream,
  one credit per symbol, credits come back on icredit pulses
*/
`timescale 1ns/100ps

module rsc_dec_sym_reader #(
  parameter int pADDR_W  = 6,
  parameter int pDTAG_W  = 8,
  parameter int pCREDITS = 4
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     rvalid_page,
  input  rsc_dec_pkg::dbits_num_t  rn,
  input  logic [pDTAG_W-1:0]       rtag,
  input  rsc_dec_pkg::llr_t        rs0,
  input  rsc_dec_pkg::llr_t        rs1,
  input  rsc_dec_pkg::llr_t        ry0,
  input  rsc_dec_pkg::llr_t        ry1,
  input  rsc_dec_pkg::llr_t        rw0,
  input  rsc_dec_pkg::llr_t        rw1,
  input  logic                     icredit,
  output logic                     rd,
  output logic [pADDR_W-1:0]       raddr,
  output logic                     page_free,
  output logic                     ovalid,
  output logic                     osop,
  output logic                     oeop,
  output rsc_dec_pkg::llr_t        os0,
  output rsc_dec_pkg::llr_t        os1,
  output rsc_dec_pkg::llr_t        oy0,
  output rsc_dec_pkg::llr_t        oy1,
  output rsc_dec_pkg::llr_t        ow0,
  output rsc_dec_pkg::llr_t        ow1,
  output logic [pDTAG_W-1:0]       otag
);

  localparam int cCW = $clog2(pCREDITS + 1);

  logic                active;   // page being read
  logic [pADDR_W-1:0]  cnt;      // symbol index
  logic [pADDR_W-1:0]  last;
  logic [cCW-1:0]      credits;
  logic                is_last;

  assign last    = pADDR_W'(rn - 1'b1);
  assign is_last = (cnt == last);
  assign rd      = active & (credits != '0);  // one credit spent per read
  assign raddr   = cnt;

  //------------------------------------------------------------
  // symbol counter and credit counter
  //------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      active    <= 1'b0;
      cnt       <= '0;
      page_free <= 1'b0;
      credits   <= cCW'(pCREDITS);
      ovalid    <= 1'b0;
      osop      <= 1'b0;
      oeop      <= 1'b0;
    end else begin
      page_free <= 1'b0;
      if (!active && !page_free && rvalid_page) begin  // old page still flagged at free
        active <= 1'b1;
        cnt    <= '0;
      end else if (rd) begin
        if (is_last) begin
          active    <= 1'b0;
          page_free <= 1'b1;  // last read issued, hand page back
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
      credits <= credits + cCW'(icredit) - cCW'(rd);
      ovalid  <= rd;  // buffer data lands with it
      osop    <= rd & (cnt == '0);
      oeop    <= rd & is_last;
    end
  end

  always_ff @(posedge iclk) begin
    if (rd) begin
      otag <= rtag;
    end
  end

  assign os0 = rs0;
  assign os1 = rs1;
  assign oy0 = ry0;
  assign oy1 = ry1;
  assign ow0 = rw0;
  assign ow1 = rw1;

endmodule
